// File: verif/gpio_lite_tests.txt
# w addr data | r addr expected | s = status read against model | p pins | t tristate
# i idle cycles | e pin_out pin_oe_n gpio_int      (all values hex)
r 00 0
r 04 0
r 08 0
r 0c 0
r 10 0
s
e 0000 ffff 0
w 00 ffffa5c3
r 00 a5c3
w 04 12345678
r 04 5678
e 5678 5a3c 0
t 00f0
e 5678 5afc 0
t 0000
r 18 0
r 02 0
w 10 000000ff
r 10 00ff
w 0c 0f0f
r 0c 0f0f
p 0303
i 5
r 08 0303
s
e 5678 5a3c 1
p 0100
i 5
s
w 14 0003
s
e 5678 5a3c 1
w 0c 000f
e 5678 5a3c 0
w 14 ffff
s

// File: list.f
hw/apb_pkg.sv
hw/gpio_pkg.sv
hw/gpio_pin_sync.sv
hw/gpio_irq.sv
hw/gpio_lite_subunit.sv
hw/gpio_lite.sv
verif/gpio_lite_assert.sv
verif/gpio_lite_checker.sv
verif/gpio_lite_tb.sv

// File: run.sh
#!/bin/sh
# build and run the GPIO testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module gpio_lite_tb -o gpio_sim
out=$(./obj_dir/gpio_sim) || true
echo "$out"
if echo "$out" | grep -qx "sim passed"
then
   exit 0
fi
exit 1

// File: verif/gpio_lite_tb.sv
/*
 * GPIO testbench top. Loads the record file, drives APB transfers and
 * pin levels, keeps the expected interrupt status and ends the run.
 */
module gpio_lite_tb;

   import gpio_pkg::*;

   localparam int drive_delay  = 2;    // after each rising edge
   localparam int reset_cycles = 16;

   logic                               pclk = 1'b0;
   logic                               reset = 1'b1;
   logic                               psel = 1'b0;
   logic                               penable = 1'b0;
   logic                               pwrite = 1'b0;
   logic [apb_pkg::apb_addr_width-1:0] paddr = '0;
   logic [apb_pkg::apb_data_width-1:0] pwdata = '0;
   logic [15:0]                        pin_in = '0;
   logic [15:0]                        tri_state_enable = '0;
   logic [apb_pkg::apb_data_width-1:0] prdata;
   logic                               gpio_int;
   logic [15:0]                        pin_oe_n;
   logic [15:0]                        pin_out;

   logic        read_cmp = 1'b0;    // to checker
   logic        pin_cmp = 1'b0;
   logic        done = 1'b0;
   logic [31:0] exp_rdata = '0;
   logic [15:0] exp_pin_out = '0;
   logic [15:0] exp_oe_n = '0;
   logic        exp_int = 1'b0;
   logic        file_ok = 1'b1;
   int          errors;
   int          cycles = 0;
   int          cycle_limit = 0;    // 0 until the file is loaded
   logic [15:0] sts_model = '0;     // expected sticky status
   logic [15:0] pol_model = '0;

   byte         rec_kind[$];
   logic [31:0] rec_a[$];
   logic [31:0] rec_b[$];
   logic [31:0] rec_c[$];

   always #20 pclk = ~pclk;

   // ------------------------------------------------------------
   // bus and pin tasks
   // ------------------------------------------------------------
   task automatic apb_write(input logic [5:0] addr, input logic [31:0] data);
      @(posedge pclk);
      #drive_delay;
      psel   = 1'b1;   // setup
      pwrite = 1'b1;
      paddr  = addr;
      pwdata = data;
      @(posedge pclk);
      #drive_delay penable = 1'b1;   // access, register takes it here
      @(posedge pclk);
      #drive_delay;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      if (addr == gpio_reg_pol) pol_model = data[15:0];
      if (addr == gpio_reg_sts) sts_model &= ~data[15:0];   // w1c
   endtask

   task automatic apb_read(input logic [5:0] addr, input logic [31:0] expected);
      @(posedge pclk);
      #drive_delay;
      psel  = 1'b1;
      paddr = addr;
      @(posedge pclk);
      #drive_delay;
      penable   = 1'b1;
      exp_rdata = expected;
      read_cmp  = 1'b1;   // checker samples prdata now
      @(posedge pclk);
      #drive_delay;
      psel     = 1'b0;
      penable  = 1'b0;
      read_cmp = 1'b0;
   endtask

   // selected edge per pin sets its status bit
   task automatic set_pins(input logic [15:0] v);
      @(posedge pclk);
      #drive_delay;
      sts_model |= (v & ~pin_in & pol_model) | (~v & pin_in & ~pol_model);
      pin_in = v;
   endtask

   task automatic expect_pins(input logic [15:0] po, input logic [15:0] oe_n,
                              input logic irq);
      @(posedge pclk);
      #drive_delay;
      exp_pin_out = po;
      exp_oe_n    = oe_n;
      exp_int     = irq;
      pin_cmp     = 1'b1;
      @(posedge pclk);
      #drive_delay pin_cmp = 1'b0;
   endtask

   task automatic run_record(input byte kind, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] c);
      case (kind)
         "w": apb_write(a[5:0], b);
         "r": apb_read(a[5:0], b);
         "s": apb_read(gpio_reg_sts, {16'h0, sts_model});   // model value
         "p": set_pins(a[15:0]);
         "t":
         begin
            @(posedge pclk);
            #drive_delay tri_state_enable = a[15:0];
         end
         "i": repeat (a) @(posedge pclk);
         "e": expect_pins(a[15:0], b[15:0], c[0]);
         default:
         begin
            $display("unknown record kind '%c' in the test file", kind);
            file_ok = 1'b0;
         end
      endcase
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial
   begin
      int          fd;
      string       line;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      fd = $fopen("verif/gpio_lite_tests.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open verif/gpio_lite_tests.txt");
         file_ok = 1'b0;
      end
      while (fd != 0 && !$feof(fd))
      begin
         a = '0;
         b = '0;
         c = '0;
         if ($fgets(line, fd) == 0) break;
         if (line.len() < 2 || line.getc(0) == "#") continue;   // blank, comment
         void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c));
         rec_kind.push_back(line.getc(0));
         rec_a.push_back(a);
         rec_b.push_back(b);
         rec_c.push_back(c);
      end
      if (fd != 0) $fclose(fd);
      cycle_limit = rec_kind.size() * 8 + reset_cycles;
      repeat (reset_cycles) @(posedge pclk);
      #drive_delay reset = 1'b0;
      foreach (rec_kind[i]) run_record(rec_kind[i], rec_a[i], rec_b[i], rec_c[i]);
      @(posedge pclk);
      #drive_delay done = 1'b1;   // checker prints its counts
      #1;
      if (errors == 0 && file_ok)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   always @(posedge pclk)
   begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit)
      begin
         $display("timeout, records not finished after %0d cycles", cycles);
         $display("sim failed");
         $finish;
      end
   end

   gpio_lite #(
      .pin_count   (16),
      .sync_stages (2)
   ) u_gpio_lite (
      .pclk             (pclk),
      .reset            (reset),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .pin_in           (pin_in),
      .tri_state_enable (tri_state_enable),
      .prdata           (prdata),
      .gpio_int         (gpio_int),
      .pin_oe_n         (pin_oe_n),
      .pin_out          (pin_out)
   );

   gpio_lite_checker u_checker (
      .pclk        (pclk),
      .read_cmp    (read_cmp),
      .exp_rdata   (exp_rdata),
      .pin_cmp     (pin_cmp),
      .exp_pin_out (exp_pin_out),
      .exp_oe_n    (exp_oe_n),
      .exp_int     (exp_int),
      .done        (done),
      .prdata      (prdata),
      .pin_out     (pin_out),
      .pin_oe_n    (pin_oe_n),
      .gpio_int    (gpio_int),
      .errors      (errors)
   );

endmodule

// File: verif/gpio_lite_checker.sv
/*
 * Compare side of the GPIO testbench. Samples prdata in the access
 * phase of reads and the pin outputs on expect records, on the
 * falling edge where the DUT outputs are settled.
 */
module gpio_lite_checker (
   input  logic        pclk,
   input  logic        read_cmp,     // access phase of a read
   input  logic [31:0] exp_rdata,
   input  logic        pin_cmp,      // expect record active
   input  logic [15:0] exp_pin_out,
   input  logic [15:0] exp_oe_n,
   input  logic        exp_int,
   input  logic        done,
   input  logic [31:0] prdata,
   input  logic [15:0] pin_out,
   input  logic [15:0] pin_oe_n,
   input  logic        gpio_int,
   output int          errors
);

   int checks = 0;
   int error_count = 0;

   assign errors = error_count;

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
      checks++;
      if (got !== expected)
      begin
         error_count++;
         $display("ERROR %s: got %h, expected %h at %0t", name, got, expected, $time);
      end
   endtask

   always @(negedge pclk)
   begin
      if (read_cmp)
         compare("prdata", prdata, exp_rdata);
      if (pin_cmp)
      begin
         compare("pin_out", {16'h0, pin_out}, {16'h0, exp_pin_out});
         compare("pin_oe_n", {16'h0, pin_oe_n}, {16'h0, exp_oe_n});
         compare("gpio_int", {31'h0, gpio_int}, {31'h0, exp_int});
      end
   end

   always @(posedge done)
      $display("checks %0d, errors %0d", checks, error_count);   // closing counts

endmodule

// File: verif/gpio_lite_assert.sv
/*
 * Concurrent checks on the GPIO top level, bound into every
 * gpio_lite instance by the bind below.
 */
module gpio_lite_assert #(
   parameter int pin_count = 16
) (
   input logic                 pclk,
   input logic                 reset,
   input logic [pin_count-1:0] tri_state_enable,
   input logic [pin_count-1:0] pin_oe_n,
   input logic                 gpio_int,
   input logic [31:0]          prdata
);

   // tristate forces the driver off
   tristate_off: assert property (@(posedge pclk)
      (pin_oe_n & tri_state_enable) == tri_state_enable)
      else $error("pin_oe_n low on a pin with tri_state_enable set");

   // quiet once reset has been seen
   int_in_reset: assert property (@(posedge pclk) reset && $past(reset) |-> !gpio_int)
      else $error("gpio_int high during reset");

   upper_zero: assert property (@(posedge pclk) (prdata >> pin_count) == 0)
      else $error("prdata nonzero above pin_count");

endmodule

bind gpio_lite gpio_lite_assert #(.pin_count(pin_count)) u_assert (.*);

// File: hw/gpio_lite.sv
/*
 * APB GPIO top level, up to 16 pins. Turns the APB phase signals
 * into read and write strobes for the register core, zero-fills
 * prdata above pin_count and ORs the pin interrupts into gpio_int.
 */
module gpio_lite #(
   parameter int pin_count   = gpio_pkg::gpio_default_pins,   // 1 to 16
   parameter int sync_stages = gpio_pkg::gpio_default_sync    // 2 or 3
) (
   input  logic                               pclk,
   input  logic                               reset,
   input  logic                               psel,
   input  logic                               penable,
   input  logic                               pwrite,
   input  logic [apb_pkg::apb_addr_width-1:0] paddr,
   input  logic [apb_pkg::apb_data_width-1:0] pwdata,
   input  logic [pin_count-1:0]               pin_in,
   input  logic [pin_count-1:0]               tri_state_enable,
   output logic [apb_pkg::apb_data_width-1:0] prdata,
   output logic                               gpio_int,
   output logic [pin_count-1:0]               pin_oe_n,
   output logic [pin_count-1:0]               pin_out
);

   import apb_pkg::*;

   logic                 rd_stb;    // setup phase of a read
   logic                 wr_stb;    // access phase of a write
   logic [pin_count-1:0] rdata;     // core read data
   logic [pin_count-1:0] pin_irq;   // per pin requests

   // ------------------------------------------------------------
   // bus side, no wait states so no pready here
   // ------------------------------------------------------------
   assign wr_stb = apb_wr_strobe(psel, penable, pwrite);
   assign rd_stb = apb_rd_strobe(psel, penable, pwrite);

   // unused upper lanes read as zero
   assign prdata = {{(apb_data_width - pin_count){1'b0}}, rdata};

   assign gpio_int = |pin_irq;   // single request line

   gpio_lite_subunit #(
      .pin_count   (pin_count),
      .sync_stages (sync_stages)
   ) u_subunit (
      .pclk             (pclk),
      .reset            (reset),
      .read             (rd_stb),
      .write            (wr_stb),
      .addr             (paddr),
      .wdata            (pwdata[pin_count-1:0]),   // low lanes only
      .pin_in           (pin_in),
      .tri_state_enable (tri_state_enable),
      .rdata            (rdata),
      .interrupt        (pin_irq),
      .pin_oe_n         (pin_oe_n),
      .pin_out          (pin_out)
   );

endmodule

// File: hw/gpio_lite_subunit.sv
/*
 * GPIO register core. Holds direction, output, enable and polarity,
 * decodes writes and the registered read mux, and drives the pins.
 * Input sync and edge interrupts live in the two child blocks.
 */
module gpio_lite_subunit #(
   parameter int pin_count   = gpio_pkg::gpio_default_pins,
   parameter int sync_stages = gpio_pkg::gpio_default_sync
) (
   input  logic                              pclk,
   input  logic                              reset,
   input  logic                              read,     // setup phase strobe
   input  logic                              write,    // access phase strobe
   input  logic [apb_pkg::apb_addr_width-1:0] addr,
   input  logic [pin_count-1:0]              wdata,
   input  logic [pin_count-1:0]              pin_in,
   input  logic [pin_count-1:0]              tri_state_enable,
   output logic [pin_count-1:0]              rdata,    // held until next read
   output logic [pin_count-1:0]              interrupt,
   output logic [pin_count-1:0]              pin_oe_n,
   output logic [pin_count-1:0]              pin_out
);

   import gpio_pkg::*;

   logic [pin_count-1:0] dir_q;     // 1 = output
   logic [pin_count-1:0] out_q;
   logic [pin_count-1:0] ien_q;
   logic [pin_count-1:0] pol_q;
   logic [pin_count-1:0] pin_sync;  // synchronized pins
   logic [pin_count-1:0] sts;       // sticky status from irq block
   logic [pin_count-1:0] sts_clr;   // w1c mask

   logic hit_dir;
   logic hit_out;
   logic hit_ien;
   logic hit_pol;
   logic hit_sts;

   // ------------------------------------------------------------
   // address decode, full compare so misaligned offsets miss
   // ------------------------------------------------------------
   assign hit_dir = (addr == gpio_reg_dir);
   assign hit_out = (addr == gpio_reg_out);
   assign hit_ien = (addr == gpio_reg_ien);
   assign hit_pol = (addr == gpio_reg_pol);
   assign hit_sts = (addr == gpio_reg_sts);

   // clear mask only during a status write
   assign sts_clr = wdata & {pin_count{write & hit_sts}};

   // ------------------------------------------------------------
   // writable registers
   // ------------------------------------------------------------
   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         dir_q <= '0;   // all pins input
         out_q <= '0;
         ien_q <= '0;
         pol_q <= '0;
      end
      else if (write)
      begin
         if (hit_dir) dir_q <= wdata;
         if (hit_out) out_q <= wdata;
         if (hit_ien) ien_q <= wdata;
         if (hit_pol) pol_q <= wdata;
      end
   end

   // ------------------------------------------------------------
   // read mux, registered in the setup phase
   // ------------------------------------------------------------
   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         rdata <= '0;
      end
      else if (read)
      begin
         case (addr)
            gpio_reg_dir: rdata <= dir_q;
            gpio_reg_out: rdata <= out_q;
            gpio_reg_in:  rdata <= pin_sync;
            gpio_reg_ien: rdata <= ien_q;
            gpio_reg_pol: rdata <= pol_q;
            gpio_reg_sts: rdata <= sts;
            default:      rdata <= '0;   // unmapped
         endcase
      end
   end

   // pin drive, tristate overrides direction
   assign pin_out  = out_q;
   assign pin_oe_n = ~dir_q | tri_state_enable;

   // ------------------------------------------------------------
   // children
   // ------------------------------------------------------------
   gpio_pin_sync #(
      .pin_count   (pin_count),
      .sync_stages (sync_stages)
   ) u_pin_sync (
      .pclk     (pclk),
      .reset    (reset),
      .pin_in   (pin_in),
      .pin_sync (pin_sync)
   );

   gpio_irq #(
      .pin_count (pin_count)
   ) u_irq (
      .pclk      (pclk),
      .reset     (reset),
      .pin_sync  (pin_sync),
      .ien       (ien_q),
      .pol       (pol_q),
      .clr       (sts_clr),
      .sts       (sts),
      .interrupt (interrupt)
   );

endmodule

// File: hw/gpio_irq.sv
/*
 * Edge interrupt block. Compares the synchronized pins against the
 * previous sample, keeps a sticky status bit per pin for the edge
 * picked by pol, and gates status with the enables.
 */
module gpio_irq #(
   parameter int pin_count = gpio_pkg::gpio_default_pins
) (
   input  logic                 pclk,
   input  logic                 reset,
   input  logic [pin_count-1:0] pin_sync,   // from synchronizer
   input  logic [pin_count-1:0] ien,        // interrupt enable
   input  logic [pin_count-1:0] pol,        // 1 rising, 0 falling
   input  logic [pin_count-1:0] clr,        // w1c mask, already decoded
   output logic [pin_count-1:0] sts,        // sticky status
   output logic [pin_count-1:0] interrupt   // per pin request
);

   logic [pin_count-1:0] prev_q;   // last synchronized sample
   logic [pin_count-1:0] rise;
   logic [pin_count-1:0] fall;
   logic [pin_count-1:0] edge_hit; // selected edge seen this cycle

   // ------------------------------------------------------------
   // edge detect
   // ------------------------------------------------------------
   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         prev_q <= '0;
      end
      else
      begin
         prev_q <= pin_sync;
      end
   end

   assign rise     = pin_sync & ~prev_q;
   assign fall     = ~pin_sync & prev_q;
   assign edge_hit = (pol & rise) | (~pol & fall);  // per pin select

   // ------------------------------------------------------------
   // sticky status, set wins over clear
   // ------------------------------------------------------------
   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         sts <= '0;
      end
      else
      begin
         sts <= (sts & ~clr) | edge_hit;
      end
   end

   // only enabled pins raise a request
   assign interrupt = sts & ien;

endmodule

// File: hw/gpio_pin_sync.sv
/*
 * Pin input synchronizer. A chain of sync_stages flops per pin
 * brings the asynchronous pad levels into the pclk domain.
 */
module gpio_pin_sync #(
   parameter int pin_count   = gpio_pkg::gpio_default_pins,
   parameter int sync_stages = gpio_pkg::gpio_default_sync
) (
   input  logic                 pclk,
   input  logic                 reset,
   input  logic [pin_count-1:0] pin_in,    // raw pad levels
   output logic [pin_count-1:0] pin_sync   // pclk domain copy
);

   // stage 0 is the metastable capture flop
   logic [pin_count-1:0] sync_q [0:sync_stages-1];

   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         for (int i = 0; i < sync_stages; i++)
         begin
            sync_q[i] <= '0;
         end
      end
      else
      begin
         sync_q[0] <= pin_in;                 // first capture
         for (int i = 1; i < sync_stages; i++)
         begin
            sync_q[i] <= sync_q[i-1];         // shift along chain
         end
      end
   end

   assign pin_sync = sync_q[sync_stages-1];  // last stage only

endmodule

// File: hw/gpio_pkg.sv
/*
 * GPIO core definitions: register map, pin count limits and the
 * default synchronizer depth. Offsets are byte addresses on the
 * APB side and are shared with the testbench.
 */
package gpio_pkg;

   // ------------------------------------------------------------
   // sizing
   localparam int gpio_max_pins     = 16;  // widest legal core
   localparam int gpio_default_pins = 16;
   localparam int gpio_default_sync = 2;   // 2 or 3 flops per pin

   // ------------------------------------------------------------
   // register map
   localparam int gpio_offset_width = 6;   // same as the APB address

   // direction, 1 = output
   localparam logic [gpio_offset_width-1:0] gpio_reg_dir = 6'h00;
   // output data
   localparam logic [gpio_offset_width-1:0] gpio_reg_out = 6'h04;
   // synchronized pins, read only
   localparam logic [gpio_offset_width-1:0] gpio_reg_in  = 6'h08;
   // interrupt enable
   localparam logic [gpio_offset_width-1:0] gpio_reg_ien = 6'h0C;
   // edge polarity, 1 = rising, 0 = falling
   localparam logic [gpio_offset_width-1:0] gpio_reg_pol = 6'h10;
   // sticky status, write 1 to clear
   localparam logic [gpio_offset_width-1:0] gpio_reg_sts = 6'h14;

   // any other offset reads 0, writes dropped

endpackage

// File: hw/apb_pkg.sv
/*
 * APB bus widths and phase decode helpers.
 * Imported by the GPIO wrapper and by the testbench driver, so both
 * sides agree on the strobe definitions.
 */
package apb_pkg;

   localparam int apb_addr_width = 6;   // byte address, 16 words
   localparam int apb_data_width = 32;  // pwdata / prdata

   // ------------------------------------------------------------
   // write strobe, access phase of a write
   function automatic logic apb_wr_strobe(input logic sel, input logic enable,
                                          input logic wr);
      return sel & enable & wr;
   endfunction

   // read strobe, setup phase of a read
   function automatic logic apb_rd_strobe(input logic sel, input logic enable,
                                          input logic wr);
      return sel & ~enable & ~wr;
   endfunction

endpackage
